// File: cnn_stream_pkg.sv
// Stream-level constants and the pixel type for the two-layer CNN engine.
// Shared by the RTL and the testbench; import where needed.
package cnn_stream_pkg;

    // ********************
    // Pixel format
    // ********************

    localparam int PIX_W = 8;            // Greyscale, unsigned.

    typedef logic [PIX_W-1:0] pix_t;

    // ********************
    // Frame geometry
    // ********************

    // Size of the frame entering layer 0.
    localparam int IN_LINE_LEN = 12;     // Pixels per line.
    localparam int IN_LINES    = 12;     // Lines per frame.

    // Side of the square convolution window.
    // Each layer trims WIN_SIZE-1 pixels from both dimensions.
    localparam int WIN_SIZE = 3;

    // ********************
    // Engine depth
    // ********************

    localparam int LAYER_NUM = 2;        // Chained conv layers.

    // Output frame of the last layer, handy for checkers.
    localparam int OUT_LINE_LEN = IN_LINE_LEN - LAYER_NUM * (WIN_SIZE - 1);
    localparam int OUT_LINES    = IN_LINES - LAYER_NUM * (WIN_SIZE - 1);

endpackage

// File: cnn_kernel_pkg.sv
// Fixed kernels and arithmetic limits of the conv layers.
// Row-major weights, index 0 is the top-left tap of the window.
package cnn_kernel_pkg;

    // ********************
    // Widths
    // ********************

    localparam int COEF_W = 6;           // Signed weight.
    localparam int ACC_W  = 20;          // Signed accumulator.

    localparam int TAPS = cnn_stream_pkg::WIN_SIZE * cnn_stream_pkg::WIN_SIZE;

    typedef logic signed [ACC_W-1:0] acc_t;

    // ********************
    // Kernels
    // ********************

    // Layer 0 smooths (sum 16), layer 1 picks edges (sum 0).
    localparam logic signed [COEF_W-1:0] KERNEL [cnn_stream_pkg::LAYER_NUM][TAPS] = '{
        '{
            6'sd1,  6'sd2,  6'sd1,
            6'sd2,  6'sd4,  6'sd2,
            6'sd1,  6'sd2,  6'sd1
        },
        '{
            -6'sd1, -6'sd1, -6'sd1,
            -6'sd1,  6'sd8, -6'sd1,
            -6'sd1, -6'sd1, -6'sd1
        }
    };

    // ********************
    // Output scaling
    // ********************

    // Arithmetic right shift before the ReLU clip.
    localparam int OUT_SHIFT [cnn_stream_pkg::LAYER_NUM] = '{4, 0};

    localparam int RELU_MAX = 255;       // Clip ceiling.

endpackage

// File: line_window.sv
// Turns a raster pixel stream into 3x3 windows with two line memories.
// Emits only complete windows and regenerates markers for the trimmed frame.
module line_window #(
    parameter int LINE_LEN = cnn_stream_pkg::IN_LINE_LEN
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  cnn_stream_pkg::pix_t pix_i,
    input  logic                 valid_i,
    input  logic                 sop_i,
    input  logic                 eop_i,
    input  logic                 sof_i,
    input  logic                 eof_i,
    output cnn_stream_pkg::pix_t win_o [cnn_stream_pkg::WIN_SIZE*cnn_stream_pkg::WIN_SIZE],
    output logic                 valid_o,
    output logic                 sop_o,
    output logic                 eop_o,
    output logic                 sof_o,
    output logic                 eof_o
);
    import cnn_stream_pkg::*;

    localparam int EDGE  = WIN_SIZE - 1;           // First full-window column and row.
    localparam int COL_W = $clog2(LINE_LEN);
    localparam int ROW_W = $clog2(WIN_SIZE + 1);

    // Line memories, index 0 holds the previous line.
    pix_t             line_mem [EDGE][LINE_LEN];
    pix_t             col_pix  [WIN_SIZE];         // New window column, top first.

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;                       // Saturates one row past EDGE.
    logic [COL_W-1:0] cur_col;
    logic [ROW_W-1:0] cur_row;
    logic             win_ok;

    // ********************
    // Position counters
    // ********************

    always_comb begin
        cur_col = (sop_i || sof_i) ? '0 : col_q;
        cur_row = sof_i ? '0 : row_q;
        win_ok  = valid_i && (cur_col >= COL_W'(EDGE)) && (cur_row >= ROW_W'(EDGE));
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (valid_i) begin
            if (eop_i) begin
                col_q <= '0;
                if (cur_row != ROW_W'(EDGE + 1)) begin
                    row_q <= cur_row + 1'b1;
                end else begin
                    row_q <= cur_row;
                end
            end else begin
                col_q <= cur_col + 1'b1;
                row_q <= cur_row;
            end
        end
    end

    // ********************
    // Line memories
    // ********************

    always_comb begin
        for (int r = 0; r < EDGE; r++) begin
            col_pix[r] = line_mem[EDGE-1-r][cur_col];
        end
        col_pix[EDGE] = pix_i;                     // Bottom row is the live pixel.
    end

    // Each line moves one memory up as the new line is written.
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            line_mem[0][cur_col] <= pix_i;
            for (int k = 1; k < EDGE; k++) begin
                line_mem[k][cur_col] <= line_mem[k-1][cur_col];
            end
        end
    end

    // ********************
    // Window shift register
    // ********************

    // Columns shift left, rightmost column takes col_pix.
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            for (int r = 0; r < WIN_SIZE; r++) begin
                for (int c = 0; c < EDGE; c++) begin
                    win_o[r*WIN_SIZE+c] <= win_o[r*WIN_SIZE+c+1];
                end
                win_o[r*WIN_SIZE+EDGE] <= col_pix[r];
            end
        end
    end

    // Markers of the trimmed frame.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            sop_o   <= 1'b0;
            eop_o   <= 1'b0;
            sof_o   <= 1'b0;
            eof_o   <= 1'b0;
        end else begin
            valid_o <= win_ok;
            sop_o   <= win_ok && (cur_col == COL_W'(EDGE));
            eop_o   <= win_ok && (cur_col == COL_W'(LINE_LEN - 1));
            sof_o   <= win_ok && (cur_col == COL_W'(EDGE)) && (cur_row == ROW_W'(EDGE));
            eof_o   <= win_ok && eof_i;        // Last row, last column.
        end
    end

    // ********************
    // Assertions
    // ********************

    // Upstream stage must qualify every marker with valid.
    a_marker_valid : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (sop_i || eop_i || sof_i || eof_i) |-> valid_i
    );

    // Line length agrees with the upstream frame.
    a_eop_col : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (valid_i && eop_i) |-> (cur_col == COL_W'(LINE_LEN - 1))
    );

endmodule

// File: conv3x3_mac.sv
// Three-stage multiply, adder tree and ReLU clip for one conv layer.
// LAYER picks the kernel and shift; markers travel beside the data.
module conv3x3_mac #(
    parameter int LAYER = 0
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  cnn_stream_pkg::pix_t win_i [cnn_stream_pkg::WIN_SIZE*cnn_stream_pkg::WIN_SIZE],
    input  logic                 valid_i,
    input  logic                 sop_i,
    input  logic                 eop_i,
    input  logic                 sof_i,
    input  logic                 eof_i,
    output cnn_stream_pkg::pix_t pix_o,
    output logic                 valid_o,
    output logic                 sop_o,
    output logic                 eop_o,
    output logic                 sof_o,
    output logic                 eof_o
);
    import cnn_stream_pkg::*;
    import cnn_kernel_pkg::*;

    localparam int DEPTH  = 3;                     // Products, tree, clip.
    localparam int CTRL_W = 5;

    acc_t              prod_q [TAPS];
    acc_t              tree_sum;
    acc_t              sum_q;
    acc_t              shifted;
    logic [CTRL_W-1:0] ctrl_q [DEPTH];

    // ********************
    // Stage 1, products
    // ********************

    // Pixels are unsigned, so a zero sign bit goes in front.
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < TAPS; k++) begin
            prod_q[k] <= $signed({1'b0, win_i[k]}) * KERNEL[LAYER][k];
        end
    end

    // ********************
    // Stage 2, adder tree
    // ********************

    always_comb begin
        tree_sum = '0;
        for (int k = 0; k < TAPS; k++) begin
            tree_sum = tree_sum + prod_q[k];
        end
    end

    always_ff @(posedge clk_i) begin
        sum_q <= tree_sum;
    end

    // ********************
    // Stage 3, shift and ReLU
    // ********************

    always_comb begin
        shifted = sum_q >>> OUT_SHIFT[LAYER];
    end

    always_ff @(posedge clk_i) begin
        if (shifted < 0) begin
            pix_o <= '0;
        end else if (shifted > RELU_MAX) begin
            pix_o <= PIX_W'(RELU_MAX);     // Saturate.
        end else begin
            pix_o <= shifted[PIX_W-1:0];
        end
    end

    // Valid and markers, one slot per data stage.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < DEPTH; s++) begin
                ctrl_q[s] <= '0;
            end
        end else begin
            ctrl_q[0] <= {valid_i, sop_i, eop_i, sof_i, eof_i};
            for (int s = 1; s < DEPTH; s++) begin
                ctrl_q[s] <= ctrl_q[s-1];
            end
        end
    end

    assign {valid_o, sop_o, eop_o, sof_o, eof_o} = ctrl_q[DEPTH-1];

    // Frame start only comes out with valid.
    a_sof_valid : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        sof_o |-> valid_o
    );

endmodule

// File: cnn_top.sv
// Two chained conv layers over an 8-bit raster stream with sop/eop/sof/eof.
// Each layer is a line_window feeding a conv3x3_mac; no back-pressure.
module cnn_top (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  cnn_stream_pkg::pix_t pix_i,
    input  logic                 valid_i,
    input  logic                 sop_i,
    input  logic                 eop_i,
    input  logic                 sof_i,
    input  logic                 eof_i,
    output cnn_stream_pkg::pix_t pix_o,
    output logic                 valid_o,
    output logic                 sop_o,
    output logic                 eop_o,
    output logic                 sof_o,
    output logic                 eof_o
);
    import cnn_stream_pkg::*;

    // Stream at each layer boundary, index 0 is the engine input.
    pix_t s_pix   [LAYER_NUM+1];
    logic s_valid [LAYER_NUM+1];
    logic s_sop   [LAYER_NUM+1];
    logic s_eop   [LAYER_NUM+1];
    logic s_sof   [LAYER_NUM+1];
    logic s_eof   [LAYER_NUM+1];

    assign s_pix[0]   = pix_i;
    assign s_valid[0] = valid_i;
    assign s_sop[0]   = sop_i;
    assign s_eop[0]   = eop_i;
    assign s_sof[0]   = sof_i;
    assign s_eof[0]   = eof_i;

    // ********************
    // Layer chain
    // ********************

    generate
        for (genvar i = 0; i < LAYER_NUM; i++) begin : g_layer
            pix_t win [WIN_SIZE*WIN_SIZE];
            logic win_valid;
            logic win_sop;
            logic win_eop;
            logic win_sof;
            logic win_eof;

            // Every layer trims WIN_SIZE-1 pixels off the line.
            line_window #(
                .LINE_LEN ( IN_LINE_LEN - i * (WIN_SIZE - 1) )
            ) u_window (
                .clk_i    ( clk_i        ),
                .arst_n_i ( arst_n_i     ),
                .pix_i    ( s_pix[i]     ),
                .valid_i  ( s_valid[i]   ),
                .sop_i    ( s_sop[i]     ),
                .eop_i    ( s_eop[i]     ),
                .sof_i    ( s_sof[i]     ),
                .eof_i    ( s_eof[i]     ),
                .win_o    ( win          ),
                .valid_o  ( win_valid    ),
                .sop_o    ( win_sop      ),
                .eop_o    ( win_eop      ),
                .sof_o    ( win_sof      ),
                .eof_o    ( win_eof      )
            );

            conv3x3_mac #(
                .LAYER ( i )
            ) u_mac (
                .clk_i    ( clk_i        ),
                .arst_n_i ( arst_n_i     ),
                .win_i    ( win          ),
                .valid_i  ( win_valid    ),
                .sop_i    ( win_sop      ),
                .eop_i    ( win_eop      ),
                .sof_i    ( win_sof      ),
                .eof_i    ( win_eof      ),
                .pix_o    ( s_pix[i+1]   ),
                .valid_o  ( s_valid[i+1] ),
                .sop_o    ( s_sop[i+1]   ),
                .eop_o    ( s_eop[i+1]   ),
                .sof_o    ( s_sof[i+1]   ),
                .eof_o    ( s_eof[i+1]   )
            );
        end
    endgenerate

    assign pix_o   = s_pix[LAYER_NUM];
    assign valid_o = s_valid[LAYER_NUM];
    assign sop_o   = s_sop[LAYER_NUM];
    assign eop_o   = s_eop[LAYER_NUM];
    assign sof_o   = s_sof[LAYER_NUM];
    assign eof_o   = s_eof[LAYER_NUM];

endmodule

// File: tb_ref_model.svh
// Golden model of the two conv layers, included inside the testbench module.
// Fill ref_in with a frame, call run_ref_model, then read ref_out.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

int ref_in  [IN_LINES][IN_LINE_LEN];
int ref_buf [IN_LINES][IN_LINE_LEN];
int ref_nxt [IN_LINES][IN_LINE_LEN];
int ref_out [OUT_LINES][OUT_LINE_LEN];

// ReLU with an upper ceiling.
function automatic int relu_clip(int value);
    if (value < 0) return 0;
    if (value > RELU_MAX) return RELU_MAX;
    return value;
endfunction

// Valid convolution, layer by layer; each layer trims the frame by two.
task automatic run_ref_model();
    int lines;
    int len;
    int acc;
    ref_buf = ref_in;
    lines   = IN_LINES;
    len     = IN_LINE_LEN;
    for (int l = 0; l < LAYER_NUM; l++) begin
        for (int r = 0; r <= lines - WIN_SIZE; r++) begin
            for (int c = 0; c <= len - WIN_SIZE; c++) begin
                acc = 0;
                for (int i = 0; i < WIN_SIZE; i++) begin
                    for (int j = 0; j < WIN_SIZE; j++) begin
                        acc = acc + ref_buf[r+i][c+j] * int'(KERNEL[l][i*WIN_SIZE+j]);
                    end
                end
                ref_nxt[r][c] = relu_clip(acc >>> OUT_SHIFT[l]);
            end
        end
        lines   = lines - (WIN_SIZE - 1);
        len     = len - (WIN_SIZE - 1);
        ref_buf = ref_nxt;
    end
    for (int r = 0; r < OUT_LINES; r++) begin
        for (int c = 0; c < OUT_LINE_LEN; c++) begin
            ref_out[r][c] = ref_buf[r][c];
        end
    end
endtask

`endif

// File: tb_cnn_top.sv
// Testbench for cnn_top: applies a table of test frames and checks every
// output pixel and marker against the included golden model.
module tb_cnn_top;
    timeunit 1ns;
    timeprecision 100ps;

    import cnn_stream_pkg::*;
    import cnn_kernel_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int FRAME_PIX = IN_LINES * IN_LINE_LEN;
    localparam int OUT_PIX   = OUT_LINES * OUT_LINE_LEN;
    localparam int TIMEOUT_CYCLES = 2 * NUM_TESTS * FRAME_PIX * 3 / 2 + 50;

    // Frame pattern kinds.
    localparam int K_RAMP  = 0;
    localparam int K_RAND  = 1;
    localparam int K_WHITE = 2;
    localparam int K_BLACK = 3;
    localparam int K_CHECK = 4;

    // ********************
    // Stimulus table
    // ********************

    string          test_name [NUM_TESTS] = '{"ramp", "random_gaps", "all_255",
                                              "checkerboard", "all_0_gaps", "back_to_back"};
    localparam int  KIND   [NUM_TESTS] = '{K_RAMP, K_RAND, K_WHITE, K_CHECK, K_BLACK, K_RAND};
    localparam bit  GAPS   [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
    localparam int  FRAMES [NUM_TESTS] = '{1, 1, 1, 1, 1, 2};

    logic clk_i;
    logic arst_n_i;
    pix_t pix_i;
    logic valid_i, sop_i, eop_i, sof_i, eof_i;
    pix_t pix_o;
    logic valid_o, sop_o, eop_o, sof_o, eof_o;

    logic [31:0] lcg_state;
    int          exp_q [$];
    int          exp_pix;
    int          out_pos;
    int          out_cnt;
    int          err_cnt;
    int          cycle_cnt;

    `include "tb_ref_model.svh"

    cnn_top dut (
        .clk_i, .arst_n_i, .pix_i, .valid_i, .sop_i, .eop_i, .sof_i, .eof_i,
        .pix_o, .valid_o, .sop_o, .eop_o, .sof_o, .eof_o
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[23:16]);
    endfunction

    task automatic make_frame(int kind);
        for (int r = 0; r < IN_LINES; r++) begin
            for (int c = 0; c < IN_LINE_LEN; c++) begin
                case (kind)
                    K_RAMP:  ref_in[r][c] = r * 20 + c;
                    K_RAND:  ref_in[r][c] = lcg_next();
                    K_WHITE: ref_in[r][c] = 255;
                    K_BLACK: ref_in[r][c] = 0;
                    default: ref_in[r][c] = ((r / 3 + c / 3) % 2) ? 255 : 0;  // 3x3 blocks.
                endcase
            end
        end
    endtask

    task automatic drive_idle();
        valid_i <= 1'b0;
        sop_i   <= 1'b0;
        eop_i   <= 1'b0;
        sof_i   <= 1'b0;
        eof_i   <= 1'b0;
    endtask

    // With gaps, every third cycle carries no pixel.
    task automatic send_frame(bit gaps);
        int slot;
        slot = 0;
        for (int r = 0; r < IN_LINES; r++) begin
            for (int c = 0; c < IN_LINE_LEN; c++) begin
                if (gaps && (slot % 3 == 2)) begin
                    @(posedge clk_i);
                    drive_idle();
                    slot++;
                end
                @(posedge clk_i);
                pix_i   <= pix_t'(ref_in[r][c]);
                valid_i <= 1'b1;
                sop_i   <= (c == 0);
                eop_i   <= (c == IN_LINE_LEN - 1);
                sof_i   <= (r == 0) && (c == 0);
                eof_i   <= (r == IN_LINES - 1) && (c == IN_LINE_LEN - 1);
                slot++;
            end
        end
    endtask

    task automatic check_value(string name, int expected, int actual);
        assert (expected == actual) else begin
            $display("MISMATCH at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    // ********************
    // Output monitor
    // ********************

    always @(posedge clk_i) begin
        if (arst_n_i && valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("Error at %0t ns: output pixel arrived with no frame expected", $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_pix = exp_q.pop_front();
                check_value("pix_o", exp_pix, int'(pix_o));
            end
            check_value("sop_o", out_pos % OUT_LINE_LEN == 0, sop_o);
            check_value("eop_o", out_pos % OUT_LINE_LEN == OUT_LINE_LEN - 1, eop_o);
            check_value("sof_o", out_pos == 0, sof_o);
            check_value("eof_o", out_pos == OUT_PIX - 1, eof_o);
            out_pos = (out_pos + 1) % OUT_PIX;
            out_cnt++;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the output frame never completed within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main_seq
        int err_base;
        pix_i     = '0;
        arst_n_i  = 1'b0;
        valid_i   = 1'b0;
        sop_i     = 1'b0;
        eop_i     = 1'b0;
        sof_i     = 1'b0;
        eof_i     = 1'b0;
        lcg_state = 32'd61;
        out_pos   = 0;
        out_cnt   = 0;
        err_cnt   = 0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        for (int t = 0; t < NUM_TESTS; t++) begin
            err_base = err_cnt;
            out_cnt  = 0;
            for (int f = 0; f < FRAMES[t]; f++) begin
                make_frame(KIND[t]);
                run_ref_model();
                for (int r = 0; r < OUT_LINES; r++) begin
                    for (int c = 0; c < OUT_LINE_LEN; c++) begin
                        exp_q.push_back(ref_out[r][c]);
                    end
                end
                send_frame(GAPS[t]);                    // Next frame follows at once.
            end
            @(posedge clk_i);
            drive_idle();
            while (exp_q.size() != 0) @(posedge clk_i);
            repeat (10) @(posedge clk_i);               // Catch stray extra pixels.
            assert (out_cnt == OUT_PIX * FRAMES[t]) else begin
                $display("Error: test %s produced %0d output pixels instead of %0d",
                         test_name[t], out_cnt, OUT_PIX * FRAMES[t]);
                err_cnt++;
            end
            $display("Test %0d %s: %0d pixels, %0d errors",
                     t, test_name[t], out_cnt, err_cnt - err_base);
        end
        $display("Tests run %0d, checks failed %0d", NUM_TESTS, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
cnn_stream_pkg.sv
cnn_kernel_pkg.sv
line_window.sv
conv3x3_mac.sv
cnn_top.sv
tb_cnn_top.sv
